// File: sim.f
design/emailbox_pkg.sv
design/emesh_write_decode.sv
design/mailbox_fifo.sv
design/mailbox_regs.sv
design/emailbox.sv
dv/emailbox_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mailbox testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module emailbox_tb \
   -Mdir obj_dir \
   -f sim.f

out=$(./obj_dir/Vemailbox_tb)
echo "$out"

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
   exit 0
else
   exit 1
fi

// File: dv/emailbox_tb.sv
module emailbox_tb
   import emailbox_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam link_id_t NODE_ID = 12'h123;
   localparam int       DEPTH   = 4;

   typedef enum logic [1:0] {OP_IDLE, OP_PKT, OP_READ, OP_WRITE} op_t;

   // one row of the stimulus table
   typedef struct packed {
      op_t         op;
      logic        wr_bit;   // packet write bit
      logic        accept;   // packet should reach the FIFO
      emesh_addr_t addr;     // mesh dst address, or mi byte address in 7:0
   } step_t;

   logic          rd_clk;
   logic          rst_n;
   logic          emesh_access;
   emesh_packet_t emesh_packet;
   logic          mi_en;
   logic          mi_we;
   mi_addr_t      mi_addr;
   mail_data_t    mi_din;
   mail_data_t    mi_dout;
   logic          mailbox_full;
   logic          mailbox_not_empty;

   step_t      steps[$];
   string      step_names[$];
   mail_data_t model_q[$];   // reference FIFO contents
   logic [31:0] lcg_state = 32'hc2d7_156c;
   int         pass_count = 0;
   int         fail_count = 0;
   int         cycle_count = 0;
   int         cycle_limit = 0;

   emailbox #(
      .ID    (NODE_ID),
      .DEPTH (DEPTH)
   ) dut_i (
      .rd_clk            (rd_clk),
      .rst_n             (rst_n),
      .emesh_access      (emesh_access),
      .emesh_packet      (emesh_packet),
      .mi_en             (mi_en),
      .mi_we             (mi_we),
      .mi_addr           (mi_addr),
      .mi_din            (mi_din),
      .mi_dout           (mi_dout),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   always #2 rd_clk = ~rd_clk;

   // run limit
   always @(posedge rd_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: the test table did not finish within %0d cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic emesh_addr_t dst_addr(link_id_t id, logic [2:0] group, reg_index_t idx);
      emesh_addr_t a;
      a        = '0;
      a[31:20] = id;
      a[10:8]  = group;
      a[7:2]   = idx;
      return a;
   endfunction

   function automatic emesh_packet_t make_packet(logic wr_bit, emesh_addr_t a, mail_data_t d);
      emesh_packet_t p;
      p         = '0;
      p[103:40] = d;
      p[39:8]   = a;
      p[1]      = wr_bit;
      return p;
   endfunction

   task automatic packet_entry(string name, logic wr_bit, link_id_t id, logic [2:0] group,
                               reg_index_t idx, logic accept);
      step_t s;
      s.op     = OP_PKT;
      s.wr_bit = wr_bit;
      s.accept = accept;
      s.addr   = dst_addr(id, group, idx);
      steps.push_back(s);
      step_names.push_back(name);
   endtask

   task automatic host_entry(string name, op_t op, reg_index_t idx);
      step_t s;
      s.op     = op;
      s.wr_bit = 1'b0;
      s.accept = 1'b0;
      s.addr   = {24'h0, idx, 2'b00};
      steps.push_back(s);
      step_names.push_back(name);
   endtask

   task automatic idle_entry(string name);
      host_entry(name, OP_IDLE, '0);
   endtask

   task automatic build_table();
      idle_entry("after_reset");
      packet_entry("reject_read_pkt", 1'b0, NODE_ID, 3'd3, E_MAILBOXLO, 1'b0);
      packet_entry("reject_bad_id", 1'b1, 12'h124, 3'd3, E_MAILBOXLO, 1'b0);
      packet_entry("reject_bad_group", 1'b1, NODE_ID, 3'd2, E_MAILBOXLO, 1'b0);
      packet_entry("reject_hi_index", 1'b1, NODE_ID, 3'd3, E_MAILBOXHI, 1'b0);
      idle_entry("idle_after_rejects");
      packet_entry("accept_first", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      host_entry("peek_lo", OP_READ, E_MAILBOXLO);
      host_entry("peek_lo_again", OP_READ, E_MAILBOXLO);
      host_entry("other_reg_read", OP_READ, 6'd0);
      host_entry("host_write_hi", OP_WRITE, E_MAILBOXHI);
      host_entry("host_write_lo", OP_WRITE, E_MAILBOXLO);
      host_entry("peek_after_writes", OP_READ, E_MAILBOXLO);
      packet_entry("accept_second", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      packet_entry("reject_mixed_id", 1'b1, 12'h023, 3'd3, E_MAILBOXLO, 1'b0);
      packet_entry("accept_third", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      host_entry("pop_first", OP_READ, E_MAILBOXHI);
      host_entry("peek_second", OP_READ, E_MAILBOXLO);
      host_entry("pop_second", OP_READ, E_MAILBOXHI);
      host_entry("pop_third", OP_READ, E_MAILBOXHI);
      idle_entry("idle_empty");
      packet_entry("fill_1", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      packet_entry("fill_2", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      packet_entry("fill_3", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      packet_entry("fill_4", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      packet_entry("fill_5_dropped", 1'b1, NODE_ID, 3'd3, E_MAILBOXLO, 1'b1);
      host_entry("other_reg_full", OP_READ, 6'd5);
      host_entry("pop_fill_1", OP_READ, E_MAILBOXHI);
      host_entry("pop_fill_2", OP_READ, E_MAILBOXHI);
      host_entry("pop_fill_3", OP_READ, E_MAILBOXHI);
      host_entry("pop_fill_4", OP_READ, E_MAILBOXHI);
      idle_entry("idle_end");
   endtask

   task automatic run_step(input int i);
      mail_data_t payload;
      mail_data_t exp_dout;
      logic [31:0] upper;
      reg_index_t idx;
      int         errs;
      errs     = 0;
      exp_dout = '0;
      payload  = {lcg_next(), 32'h0};
      payload[31:0] = lcg_next();
      idx      = steps[i].addr[7:2];
      @(posedge rd_clk);
      case (steps[i].op)
         OP_PKT: begin
            emesh_access <= 1'b1;
            emesh_packet <= make_packet(steps[i].wr_bit, steps[i].addr, payload);
            if (steps[i].accept && model_q.size() < DEPTH) begin
               model_q.push_back(payload);   // dropped when full
            end
         end
         OP_READ: begin
            mi_en   <= 1'b1;
            mi_we   <= 1'b0;
            mi_addr <= steps[i].addr[7:0];
            if (idx == E_MAILBOXLO || idx == E_MAILBOXHI) begin
               assert (model_q.size() > 0) else begin
                  $display("%s: the table reads the mailbox while it is empty", step_names[i]);
                  errs++;
               end
               if (model_q.size() > 0) begin
                  upper = model_q[0][63:32];
                  exp_dout = (idx == E_MAILBOXLO) ? model_q[0] : {upper, upper};
                  if (idx == E_MAILBOXHI) model_q.pop_front();
               end
            end
         end
         OP_WRITE: begin
            mi_en   <= 1'b1;
            mi_we   <= 1'b1;
            mi_addr <= steps[i].addr[7:0];
            mi_din  <= payload;
         end
         default: ;
      endcase
      @(posedge rd_clk);
      emesh_access <= 1'b0;
      mi_en        <= 1'b0;
      mi_we        <= 1'b0;
      @(negedge rd_clk);
      assert (mi_dout === exp_dout) else begin
         $display("Error: %s mi_dout expected %h actual %h", step_names[i], exp_dout, mi_dout);
         errs++;
      end
      @(posedge rd_clk);
      @(negedge rd_clk);   // status settled two cycles after the strobe
      assert (mi_dout === '0) else begin
         $display("Error: %s idle mi_dout expected %h actual %h", step_names[i], 64'h0, mi_dout);
         errs++;
      end
      assert (mailbox_not_empty === (model_q.size() != 0)) else begin
         $display("Error: %s not_empty expected %b actual %b", step_names[i],
                  model_q.size() != 0, mailbox_not_empty);
         errs++;
      end
      assert (mailbox_full === (model_q.size() == DEPTH)) else begin
         $display("Error: %s full expected %b actual %b", step_names[i],
                  model_q.size() == DEPTH, mailbox_full);
         errs++;
      end
      if (errs == 0) begin
         pass_count++;
         $display("test %-20s passed", step_names[i]);
      end else begin
         fail_count++;
         $display("test %-20s failed", step_names[i]);
      end
   endtask

   initial begin
      rd_clk       = 1'b0;
      rst_n        = 1'b0;
      emesh_access = 1'b0;
      emesh_packet = '0;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      mi_din       = '0;
      build_table();
      cycle_limit = 8 * steps.size() + 64;
      repeat (16) @(posedge rd_clk);
      rst_n <= 1'b1;
      for (int i = 0; i < steps.size(); i++) begin
         run_step(i);
      end
      $display("tests: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: design/emailbox.sv
module emailbox
   import emailbox_pkg::*;
#(
   parameter link_id_t ID    = 12'h000,
   parameter int       DEPTH = 16
) (
   input  logic          rd_clk,
   input  logic          rst_n,
   input  logic          emesh_access,
   input  emesh_packet_t emesh_packet,
   input  logic          mi_en,
   input  logic          mi_we,
   input  mi_addr_t      mi_addr,
   input  mail_data_t    mi_din,
   output mail_data_t    mi_dout,
   output logic          mailbox_full,
   output logic          mailbox_not_empty
);

   logic       wr_en;
   mail_data_t wr_data;
   logic       rd_en;
   mail_data_t rd_data;
   logic       mailbox_empty;

   // mesh side, filtered pushes
   emesh_write_decode #(
      .ID (ID)
   ) decode_i (
      .rd_clk       (rd_clk),
      .rst_n        (rst_n),
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .wr_en        (wr_en),
      .wr_data      (wr_data)
   );

   mailbox_fifo #(
      .DEPTH (DEPTH)
   ) fifo_i (
      .rd_clk  (rd_clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_data (rd_data),
      .full    (mailbox_full),
      .empty   (mailbox_empty)
   );

   // host register port
   mailbox_regs regs_i (
      .rd_clk  (rd_clk),
      .rst_n   (rst_n),
      .mi_en   (mi_en),
      .mi_we   (mi_we),
      .mi_addr (mi_addr),
      .mi_din  (mi_din),
      .mi_dout (mi_dout),
      .rd_en   (rd_en),
      .rd_data (rd_data)
   );

   assign mailbox_not_empty = ~mailbox_empty;

endmodule

// File: design/mailbox_regs.sv
module mailbox_regs
   import emailbox_pkg::*;
(
   input  logic       rd_clk,
   input  logic       rst_n,
   input  logic       mi_en,
   input  logic       mi_we,
   input  mi_addr_t   mi_addr,
   input  mail_data_t mi_din,   // host writes go nowhere
   output mail_data_t mi_dout,
   output logic       rd_en,
   input  mail_data_t rd_data
);

   reg_index_t mi_reg;
   logic       mi_rd;
   mail_half_t head_hi;
   mail_data_t dout_next;

   assign mi_reg  = mi_addr[MI_REG_LSB +: REG_INDEX_W];
   assign mi_rd   = mi_en & ~mi_we;
   assign head_hi = rd_data[MAIL_HALF_W +: MAIL_HALF_W];

   // reading the high word retires the head entry
   assign rd_en = mi_rd & (mi_reg == E_MAILBOXHI);

   // read data select
   always_comb begin
      dout_next = '0;
      if (mi_rd) begin
         case (mi_reg)
            E_MAILBOXLO: dout_next = rd_data;            // peek, no pop
            E_MAILBOXHI: dout_next = {head_hi, head_hi}; // upper word twice
            default:     dout_next = '0;
         endcase
      end
   end

   // held for a single cycle, zero otherwise
   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         mi_dout <= '0;
      end else begin
         mi_dout <= dout_next;
      end
   end

endmodule

// File: design/mailbox_fifo.sv
module mailbox_fifo
   import emailbox_pkg::*;
#(
   parameter int DEPTH = 16 // power of two
) (
   input  logic       rd_clk,
   input  logic       rst_n,
   input  logic       wr_en,
   input  mail_data_t wr_data,
   input  logic       rd_en,
   output mail_data_t rd_data,
   output logic       full,
   output logic       empty
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   typedef logic [AW:0]   fifo_ptr_t;   // extra bit tells wrap
   typedef logic [AW-1:0] fifo_addr_t;

   mail_data_t mem [DEPTH];

   fifo_ptr_t  wr_ptr;
   fifo_ptr_t  rd_ptr;
   fifo_addr_t wr_addr;
   fifo_addr_t rd_addr;
   logic       ptr_wrapped;
   logic       do_write;
   logic       do_read;

   assign wr_addr = wr_ptr[AW-1:0];
   assign rd_addr = rd_ptr[AW-1:0];

   // same slot, laps differ -> full
   assign ptr_wrapped = wr_ptr[AW] ^ rd_ptr[AW];
   assign full        = ptr_wrapped & (wr_addr == rd_addr);
   assign empty       = (wr_ptr == rd_ptr);

   // overflow and underflow dropped here
   assign do_write = wr_en & ~full;
   assign do_read  = rd_en & ~empty;

   always_ff @(posedge rd_clk) begin
      if (do_write) begin
         mem[wr_addr] <= wr_data;
      end
   end

   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (do_write) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (do_read) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // show-ahead, head is always visible
   assign rd_data = mem[rd_addr];

endmodule

// File: design/emesh_write_decode.sv
module emesh_write_decode
   import emailbox_pkg::*;
#(
   parameter link_id_t ID = 12'h000
) (
   input  logic          rd_clk,
   input  logic          rst_n,
   input  logic          emesh_access,
   input  emesh_packet_t emesh_packet,
   output logic          wr_en,
   output mail_data_t    wr_data
);

   emesh_addr_t emesh_addr;
   mail_data_t  emesh_din;
   link_id_t    dst_id;
   reg_group_t  dst_group;
   reg_index_t  dst_reg;
   logic        is_write;
   logic        accept;

   // split the packet into its fields
   assign emesh_addr = emesh_packet[PKT_ADDR_LSB +: ADDR_W];
   assign emesh_din  = emesh_packet[PKT_DATA_LSB +: MAIL_W];
   assign is_write   = emesh_packet[PKT_WRITE_BIT];

   assign dst_id    = emesh_addr[ADDR_ID_LSB +: LINK_ID_W];
   assign dst_group = emesh_addr[ADDR_GROUP_LSB +: GROUP_W];
   assign dst_reg   = emesh_addr[ADDR_REG_LSB +: REG_INDEX_W];

   // only writes to this link's mailbox-low register go in
   assign accept = emesh_access
                 & is_write
                 & (dst_id == ID)
                 & (dst_group == MAILBOX_GROUP)
                 & (dst_reg == E_MAILBOXLO);

   // one-cycle push strobe
   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= accept;
      end
   end

   // payload follows the strobe
   always_ff @(posedge rd_clk) begin
      if (accept) begin
         wr_data <= emesh_din;
      end
   end

endmodule

// File: design/emailbox_pkg.sv
package emailbox_pkg;

   // field widths
   localparam int PACKET_W    = 104;
   localparam int ADDR_W      = 32;
   localparam int MAIL_W      = 64;
   localparam int MAIL_HALF_W = MAIL_W / 2;
   localparam int MI_ADDR_W   = 8;
   localparam int REG_INDEX_W = 6;
   localparam int LINK_ID_W   = 12;
   localparam int GROUP_W     = 3;

   typedef logic [PACKET_W-1:0]    emesh_packet_t;
   typedef logic [ADDR_W-1:0]      emesh_addr_t;
   typedef logic [MAIL_W-1:0]      mail_data_t;
   typedef logic [MAIL_HALF_W-1:0] mail_half_t;
   typedef logic [MI_ADDR_W-1:0]   mi_addr_t;
   typedef logic [REG_INDEX_W-1:0] reg_index_t;
   typedef logic [LINK_ID_W-1:0]   link_id_t;
   typedef logic [GROUP_W-1:0]     reg_group_t;

   // mesh packet layout
   localparam int PKT_WRITE_BIT = 1;   // set on write transactions
   localparam int PKT_ADDR_LSB  = 8;   // dst address at 39:8
   localparam int PKT_DATA_LSB  = 40;  // payload at 103:40

   // destination address layout
   localparam int ADDR_ID_LSB    = 20; // link id at 31:20
   localparam int ADDR_GROUP_LSB = 8;  // register group at 10:8
   localparam int ADDR_REG_LSB   = 2;  // word index at 7:2

   // mi byte address, word index at 7:2
   localparam int MI_REG_LSB = 2;

   // register map
   localparam reg_group_t MAILBOX_GROUP = 3'd3;
   localparam reg_index_t E_MAILBOXLO   = 6'd9;
   localparam reg_index_t E_MAILBOXHI   = 6'd10;

endpackage
